// ==== Bender.yml ====
package:
  name: lockstep_checker

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lockstep_pkg.sv
      - core/lockstep_core.sv
      - src/shadow_reset_gen.sv
      - src/delay_line.sv
      - src/output_compare.sv
      - src/lockstep_top.sv
      - target: test
        files:
          - tb/tb_lockstep.sv

// ==== common/lockstep_params.svh ====
// Lockstep checker parameters: offset, bus widths, opcode field and reset PC
`ifndef LOCKSTEP_PARAMS_SVH
`define LOCKSTEP_PARAMS_SVH

// Cycles the shadow core lags the main core, at least 1
`define LOCKSTEP_OFFSET 2

// Reset release counter, wide enough to hold the offset
`define LOCKSTEP_CNT_W ($clog2(`LOCKSTEP_OFFSET + 1))

// Bus widths
`define ADDR_W 32
`define DATA_W 32

// Opcode sits in the top bits of the instruction word
`define OPCODE_W 4

// Immediate takes the remaining low bits, zero-extended
`define IMM_W (`DATA_W - `OPCODE_W)

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== common/lockstep_pkg.sv ====
// Lockstep checker types for the core FSM, the opcodes and the delayed bus bundles
`default_nettype none

`include "lockstep_params.svh"

package lockstep_pkg;

  // Opcode field, anything not listed is illegal
  typedef enum logic [`OPCODE_W-1:0] {
    OP_NOP   = 4'd0,
    OP_LI    = 4'd1,
    OP_ADD   = 4'd2,
    OP_STORE = 4'd3,
    OP_JUMP  = 4'd4
  } opcode_e;

  // Core FSM
  typedef enum logic [1:0] {
    FETCH      = 2'd0,
    WAIT_RDATA = 2'd1,
    EXEC       = 2'd2,
    STORE      = 2'd3
  } core_state_e;

  // Bus responses seen by the core, 35 bits
  typedef struct packed {
    logic               instr_gnt;
    logic               instr_rvalid;
    logic [`DATA_W-1:0] instr_rdata;
    logic               data_gnt;
  } core_in_t;

  // Bus requests driven by the core, 98 bits
  typedef struct packed {
    logic               instr_req;
    logic [`ADDR_W-1:0] instr_addr;
    logic               data_req;
    logic [`ADDR_W-1:0] data_addr;
    logic [`DATA_W-1:0] data_wdata;
  } core_out_t;

endpackage

`default_nettype wire

// ==== core/lockstep_core.sv ====
// Small accumulator core with instruction fetch and word store buses
`timescale 1ns/100ps
`default_nettype none

`include "lockstep_params.svh"

module lockstep_core (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Instruction fetch
  output logic               instr_req_o,
  output logic [`ADDR_W-1:0] instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  logic [`DATA_W-1:0] instr_rdata_i,

  // Data store
  output logic               data_req_o,
  output logic [`ADDR_W-1:0] data_addr_o,
  output logic [`DATA_W-1:0] data_wdata_o,
  input  logic               data_gnt_i,

  output logic               illegal_instr_o
);

  lockstep_pkg::core_state_e state_q, state_d;
  logic [`ADDR_W-1:0]        pc_q, pc_d;
  logic [`DATA_W-1:0]        acc_q, acc_d;
  logic [`DATA_W-1:0]        instr_q;

  lockstep_pkg::opcode_e     opcode;
  logic [`DATA_W-1:0]        imm;
  logic                      opcode_legal;
  logic                      store_active;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign opcode = lockstep_pkg::opcode_e'(instr_q[`DATA_W-1 -: `OPCODE_W]);
  assign imm    = {{`OPCODE_W{1'b0}}, instr_q[`IMM_W-1:0]};

  always_comb begin
    case (opcode)
      lockstep_pkg::OP_NOP,
      lockstep_pkg::OP_LI,
      lockstep_pkg::OP_ADD,
      lockstep_pkg::OP_STORE,
      lockstep_pkg::OP_JUMP: opcode_legal = 1'b1;
      default:               opcode_legal = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM and datapath
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    acc_d   = acc_q;

    case (state_q)
      lockstep_pkg::FETCH: begin
        if (instr_gnt_i) begin
          state_d = lockstep_pkg::WAIT_RDATA;
        end
      end
      lockstep_pkg::WAIT_RDATA: begin
        if (instr_rvalid_i) begin
          state_d = lockstep_pkg::EXEC;
        end
      end
      lockstep_pkg::EXEC: begin
        // Single cycle, illegal opcodes fall through as NOP
        state_d = lockstep_pkg::FETCH;
        pc_d    = pc_q + `ADDR_W'(4);
        case (opcode)
          lockstep_pkg::OP_LI:    acc_d   = imm;
          lockstep_pkg::OP_ADD:   acc_d   = acc_q + imm;
          lockstep_pkg::OP_STORE: state_d = lockstep_pkg::STORE;
          lockstep_pkg::OP_JUMP:  pc_d    = `ADDR_W'(imm);
          default: ;
        endcase
      end
      lockstep_pkg::STORE: begin
        if (data_gnt_i) begin
          state_d = lockstep_pkg::FETCH;
        end
      end
      default: state_d = lockstep_pkg::FETCH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lockstep_pkg::FETCH;
      pc_q    <= `RESET_PC;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      acc_q   <= acc_d;
    end
  end

  // Instruction register
  always_ff @(posedge clk_i) begin
    if (state_q == lockstep_pkg::WAIT_RDATA && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  // Bus outputs
  assign store_active    = (state_q == lockstep_pkg::STORE);

  assign instr_req_o     = (state_q == lockstep_pkg::FETCH);
  assign instr_addr_o    = pc_q;

  // Store bus is zero while idle
  assign data_req_o      = store_active;
  assign data_addr_o     = store_active ? `ADDR_W'(imm) : '0;
  assign data_wdata_o    = store_active ? acc_q : '0;

  assign illegal_instr_o = (state_q == lockstep_pkg::EXEC) & ~opcode_legal;

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/lockstep_pkg.sv
core/lockstep_core.sv
src/shadow_reset_gen.sv
src/delay_line.sv
src/output_compare.sv
src/lockstep_top.sv
tb/tb_lockstep.sv

// ==== src/delay_line.sv ====
// Fixed-depth shift register delaying one packed bundle by the lockstep offset
`timescale 1ns/100ps
`default_nettype none

`include "lockstep_params.svh"

module delay_line #(
  parameter int unsigned Width = 1
) (
  input  logic             clk_i,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  // Stage 0 takes the input, last stage drives the output
  logic [Width-1:0] stage_q [`LOCKSTEP_OFFSET];

  // Always shifts, no reset and no enable
  always_ff @(posedge clk_i) begin
    stage_q[0] <= data_i;
    for (int unsigned i = 1; i < `LOCKSTEP_OFFSET; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  assign data_o = stage_q[`LOCKSTEP_OFFSET-1];

endmodule

`default_nettype wire

// ==== src/lockstep_top.sv ====
// Lockstep checker top: delayed shadow core compared against the main core outputs
`timescale 1ns/100ps
`default_nettype none

`include "lockstep_params.svh"

module lockstep_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Main core outputs
  input  logic               instr_req_i,
  input  logic [`ADDR_W-1:0] instr_addr_i,
  input  logic               data_req_i,
  input  logic [`ADDR_W-1:0] data_addr_i,
  input  logic [`DATA_W-1:0] data_wdata_i,

  // Bus responses to the main core
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  logic [`DATA_W-1:0] instr_rdata_i,
  input  logic               data_gnt_i,

  output logic               alert_minor_o,
  output logic               alert_major_o
);

  logic                    shadow_rst_n;
  logic                    shadow_active;
  logic                    shadow_illegal;

  lockstep_pkg::core_in_t  main_in;
  lockstep_pkg::core_in_t  shadow_in;
  lockstep_pkg::core_out_t main_out;
  lockstep_pkg::core_out_t main_out_dly;
  lockstep_pkg::core_out_t shadow_out;

  ////////////////////////////////////////////////////////////////////////////
  // Shadow reset
  ////////////////////////////////////////////////////////////////////////////

  shadow_reset_gen u_shadow_reset_gen (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .shadow_rst_no   (shadow_rst_n),
    .shadow_active_o (shadow_active)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Input and output delays
  ////////////////////////////////////////////////////////////////////////////

  assign main_in.instr_gnt    = instr_gnt_i;
  assign main_in.instr_rvalid = instr_rvalid_i;
  assign main_in.instr_rdata  = instr_rdata_i;
  assign main_in.data_gnt     = data_gnt_i;

  delay_line #(
    .Width ($bits(lockstep_pkg::core_in_t))
  ) u_in_delay (
    .clk_i  (clk_i),
    .data_i (main_in),
    .data_o (shadow_in)
  );

  assign main_out.instr_req   = instr_req_i;
  assign main_out.instr_addr  = instr_addr_i;
  assign main_out.data_req    = data_req_i;
  assign main_out.data_addr   = data_addr_i;
  assign main_out.data_wdata  = data_wdata_i;

  delay_line #(
    .Width ($bits(lockstep_pkg::core_out_t))
  ) u_out_delay (
    .clk_i  (clk_i),
    .data_i (main_out),
    .data_o (main_out_dly)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shadow core and compare
  ////////////////////////////////////////////////////////////////////////////

  lockstep_core u_shadow_core (
    .clk_i           (clk_i),
    .rst_ni          (shadow_rst_n),
    .instr_req_o     (shadow_out.instr_req),
    .instr_addr_o    (shadow_out.instr_addr),
    .instr_gnt_i     (shadow_in.instr_gnt),
    .instr_rvalid_i  (shadow_in.instr_rvalid),
    .instr_rdata_i   (shadow_in.instr_rdata),
    .data_req_o      (shadow_out.data_req),
    .data_addr_o     (shadow_out.data_addr),
    .data_wdata_o    (shadow_out.data_wdata),
    .data_gnt_i      (shadow_in.data_gnt),
    .illegal_instr_o (shadow_illegal)
  );

  output_compare u_output_compare (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .shadow_active_i  (shadow_active),
    .main_out_i       (main_out_dly),
    .shadow_out_i     (shadow_out),
    .shadow_illegal_i (shadow_illegal),
    .alert_minor_o    (alert_minor_o),
    .alert_major_o    (alert_major_o)
  );

endmodule

`default_nettype wire

// ==== src/output_compare.sv ====
// Registered compare of delayed main outputs against shadow outputs, with alerts
`timescale 1ns/100ps
`default_nettype none

module output_compare (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    shadow_active_i,
  input  lockstep_pkg::core_out_t main_out_i,
  input  lockstep_pkg::core_out_t shadow_out_i,
  input  logic                    shadow_illegal_i,

  output logic                    alert_minor_o,
  output logic                    alert_major_o
);

  logic mismatch;

  // Any bit of the bundle counts, ignored until the shadow is out of reset
  assign mismatch = shadow_active_i & (main_out_i != shadow_out_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_major_o <= 1'b0;
      alert_minor_o <= 1'b0;
    end else begin
      alert_major_o <= mismatch;
      // One cycle after the shadow EXEC cycle
      alert_minor_o <= shadow_illegal_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/shadow_reset_gen.sv ====
// Shadow core reset release a fixed number of cycles after the main reset
`timescale 1ns/100ps
`default_nettype none

`include "lockstep_params.svh"

module shadow_reset_gen (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic shadow_active_o
);

  localparam logic [`LOCKSTEP_CNT_W-1:0] offset_cnt = `LOCKSTEP_OFFSET;

  logic [`LOCKSTEP_CNT_W-1:0] cnt_q, cnt_d;
  logic                       set_q, set_d;

  // Saturates at the offset
  assign cnt_d = (cnt_q == offset_cnt) ? cnt_q : cnt_q + 1'b1;
  assign set_d = (cnt_d == offset_cnt);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      set_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      set_q <= set_d;
    end
  end

  assign shadow_rst_no   = set_q;
  assign shadow_active_o = set_q;

endmodule

`default_nettype wire

// ==== tb/tb_lockstep.sv ====
// Lockstep checker testbench with a main core model, random memory and fault injection
`timescale 1ns/100ps
`default_nettype none

`include "lockstep_params.svh"

module tb_lockstep;

  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DLY     = 2;
  localparam int SEED          = 78;
  localparam int OFF           = `LOCKSTEP_OFFSET;
  localparam int RESET_CYCLES  = 3;
  localparam int RUN_CLEAN     = 400;
  localparam int RUN_FAULT     = 600;
  localparam int RUN_AFTER     = 300;
  localparam int TOTAL_CYCLES  = 2 * RESET_CYCLES + RUN_CLEAN + RUN_FAULT + RUN_AFTER;
  localparam int TIMEOUT_CYCLES = TOTAL_CYCLES + 100;
  localparam int MAX_CYC       = 2048;
  localparam int PROG_WORDS    = 64;

  // Core FSM states and opcodes
  localparam int ST_FETCH = 0;
  localparam int ST_WAIT  = 1;
  localparam int ST_EXEC  = 2;
  localparam int ST_STORE = 3;
  localparam logic [3:0] OP_NOP   = 4'd0;
  localparam logic [3:0] OP_LI    = 4'd1;
  localparam logic [3:0] OP_ADD   = 4'd2;
  localparam logic [3:0] OP_STORE = 4'd3;
  localparam logic [3:0] OP_JUMP  = 4'd4;

  localparam int FAULT_NONE   = 0;
  localparam int FAULT_RANDOM = 1;
  localparam int FAULT_FORCED = 2;

  logic               clk_i;
  logic               rst_ni;
  logic               instr_req;
  logic [`ADDR_W-1:0] instr_addr;
  logic               data_req;
  logic [`ADDR_W-1:0] data_addr;
  logic [`DATA_W-1:0] data_wdata;
  logic               instr_gnt;
  logic               instr_rvalid;
  logic [`DATA_W-1:0] instr_rdata;
  logic               data_gnt;
  logic               alert_minor;
  logic               alert_major;

  // Main core model
  int                 m_state;
  logic [31:0]        m_pc;
  logic [31:0]        m_acc;
  logic [31:0]        m_instr;

  // Memory state and last driven responses
  logic [31:0]        mem [PROG_WORDS];
  bit                 rd_pending;
  int                 rd_wait;
  logic [31:0]        rd_addr;
  logic               r_gnt;
  logic               r_rvalid;
  logic [31:0]        r_rdata;
  logic               r_dgnt;

  // Per-cycle history for expected alerts
  bit                 fault_hist   [MAX_CYC];
  bit                 illegal_hist [MAX_CYC];
  bit                 active_hist  [MAX_CYC];
  int                 rel_cnt;
  int                 cyc;

  int unsigned        seed_val;
  int                 checks;
  int                 errors;
  int                 fetch_faults;
  int                 store_faults;
  int                 masked_faults;
  int                 illegal_execs;

  lockstep_top uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .data_req_i     (data_req),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .data_gnt_i     (data_gnt),
    .alert_minor_o  (alert_minor),
    .alert_major_o  (alert_major)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h in cycle %0d", name, got, exp, cyc);
    end
  endtask

  function automatic logic [31:0] imm_of(input logic [31:0] word);
    return {4'b0000, word[27:0]};
  endfunction

  // Last word jumps home, other jumps only go forward so the program never stalls
  task automatic build_program(input bit with_illegal);
    int r;
    int target;
    for (int i = 0; i < PROG_WORDS; i++) begin
      r = $urandom % 16;
      if (i == PROG_WORDS - 1) begin
        mem[i] = {OP_JUMP, 28'd0};
      end else if (with_illegal && r < 2) begin
        mem[i] = {4'(5 + $urandom % 11), 28'($urandom)};
      end else if (r < 4) begin
        mem[i] = {OP_NOP, 28'($urandom)};
      end else if (r < 8) begin
        mem[i] = {OP_LI, 28'($urandom)};
      end else if (r < 11) begin
        mem[i] = {OP_ADD, 28'($urandom)};
      end else if (r < 14) begin
        mem[i] = {OP_STORE, 28'($urandom)};
      end else begin
        target = i + 1 + $urandom % (PROG_WORDS - 1 - i);
        mem[i] = {OP_JUMP, 28'(target * 4)};
      end
    end
  endtask

  task automatic reset_model();
    m_state = ST_FETCH;
    m_pc    = `RESET_PC;
    m_acc   = '0;
  endtask

  // One clock edge of the main core, using the responses of the cycle that ends
  task automatic step_model();
    case (m_state)
      ST_FETCH: if (r_gnt) m_state = ST_WAIT;
      ST_WAIT: begin
        if (r_rvalid) begin
          m_instr = r_rdata;
          m_state = ST_EXEC;
        end
      end
      ST_EXEC: begin
        m_state = ST_FETCH;
        m_pc    = m_pc + 32'd4;
        case (m_instr[31:28])
          OP_LI:    m_acc   = imm_of(m_instr);
          OP_ADD:   m_acc   = m_acc + imm_of(m_instr);
          OP_STORE: m_state = ST_STORE;
          OP_JUMP:  m_pc    = imm_of(m_instr);
          default: ;
        endcase
      end
      default: if (r_dgnt) m_state = ST_FETCH;
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One bus cycle
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_cycle(input logic rst_val, input int fault_mode);
    logic        o_req;
    logic        o_dreq;
    logic [31:0] o_daddr;
    logic [31:0] o_wdata;
    logic [31:0] d_addr;
    logic        fault;
    bit          act;
    bit          exp_major;
    bit          exp_minor;
    @(posedge clk_i);
    if (rst_ni) step_model();
    #DRIVE_DLY;
    rst_ni = rst_val;
    if (!rst_val) begin
      reset_model();
      rd_pending = 1'b0;
    end

    o_req   = (m_state == ST_FETCH);
    o_dreq  = (m_state == ST_STORE);
    o_daddr = o_dreq ? imm_of(m_instr) : '0;
    o_wdata = o_dreq ? m_acc : '0;

    // Memory answers the undelayed requests
    r_gnt    = 1'b0;
    r_rvalid = 1'b0;
    r_rdata  = $urandom;
    r_dgnt   = 1'b0;
    if (rst_val) begin
      if (rd_pending) begin
        if (rd_wait == 0) begin
          r_rvalid   = 1'b1;
          r_rdata    = mem[(rd_addr >> 2) % PROG_WORDS];
          rd_pending = 1'b0;
        end else begin
          rd_wait--;
        end
      end
      if (o_req && ($urandom % 100) < 60) begin
        r_gnt      = 1'b1;
        rd_pending = 1'b1;
        rd_wait    = $urandom % 3;
        rd_addr    = m_pc;
      end
      if (o_dreq && ($urandom % 100) < 50) r_dgnt = 1'b1;
    end

    // Bit flips on the driven ports only, the model state stays intact
    fault  = 1'b0;
    d_addr = m_pc;
    if (fault_mode == FAULT_RANDOM) begin
      if (o_dreq && ($urandom % 3) == 0) begin
        fault = 1'b1;
        store_faults++;
        if ($urandom % 2) o_daddr = o_daddr ^ (32'h1 << ($urandom % 32));
        else o_wdata = o_wdata ^ (32'h1 << ($urandom % 32));
      end else if (($urandom % 16) == 0) begin
        fault = 1'b1;
        fetch_faults++;
        if (($urandom % 4) == 0) o_req = ~o_req;
        else d_addr = d_addr ^ (32'h1 << ($urandom % 32));
      end
    end else if (fault_mode == FAULT_FORCED) begin
      fault  = 1'b1;
      d_addr = d_addr ^ (32'h1 << ($urandom % 32));
      masked_faults++;
    end

    instr_req    = o_req;
    instr_addr   = d_addr;
    data_req     = o_dreq;
    data_addr    = o_daddr;
    data_wdata   = o_wdata;
    instr_gnt    = r_gnt;
    instr_rvalid = r_rvalid;
    instr_rdata  = r_rdata;
    data_gnt     = r_dgnt;

    // Shadow runs OFF cycles after release
    if (!rst_val) begin
      rel_cnt = 0;
      act     = 1'b0;
    end else begin
      act = (rel_cnt >= OFF);
      if (rel_cnt < OFF) rel_cnt++;
    end
    active_hist[cyc]  = act;
    fault_hist[cyc]   = fault;
    illegal_hist[cyc] = rst_val && m_state == ST_EXEC && m_instr[31:28] > OP_JUMP;
    if (illegal_hist[cyc]) illegal_execs++;

    @(negedge clk_i);
    exp_major = 1'b0;
    exp_minor = 1'b0;
    if (rst_val && cyc > OFF && active_hist[cyc-1]) begin
      exp_major = fault_hist[cyc-1-OFF];
      exp_minor = illegal_hist[cyc-1-OFF];
    end
    check_value("alert_major_o", 32'(alert_major), 32'(exp_major));
    check_value("alert_minor_o", 32'(alert_minor), 32'(exp_minor));
    cyc++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed_val     = $urandom(SEED);
    rst_ni       = 1'b0;
    instr_req    = 1'b0;
    instr_addr   = '0;
    data_req     = 1'b0;
    data_addr    = '0;
    data_wdata   = '0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    data_gnt     = 1'b0;
    r_gnt        = 1'b0;
    r_rvalid     = 1'b0;
    r_rdata      = '0;
    r_dgnt       = 1'b0;
    rd_pending   = 1'b0;
    rd_wait      = 0;
    rd_addr      = '0;
    m_instr      = '0;
    rel_cnt      = 0;
    cyc          = 0;
    checks       = 0;
    errors       = 0;
    fetch_faults = 0;
    store_faults = 0;
    masked_faults = 0;
    illegal_execs = 0;
    reset_model();
    build_program(1'b0);

    repeat (RESET_CYCLES) run_cycle(1'b0, FAULT_NONE);
    repeat (RUN_CLEAN) run_cycle(1'b1, FAULT_NONE);

    // Illegal opcodes and injected faults
    build_program(1'b1);
    repeat (RUN_FAULT) run_cycle(1'b1, FAULT_RANDOM);

    // Second reset, faults in its last cycles reach the compare before the shadow runs
    build_program(1'b0);
    for (int i = 0; i < RESET_CYCLES; i++) begin
      run_cycle(1'b0, (i >= RESET_CYCLES - OFF) ? FAULT_FORCED : FAULT_NONE);
    end
    repeat (RUN_AFTER) run_cycle(1'b1, FAULT_NONE);

    if (fetch_faults == 0) begin
      errors++;
      $display("no faults were injected on the fetch bus");
    end
    if (store_faults == 0) begin
      errors++;
      $display("no faults were injected on the store bus");
    end
    if (illegal_execs == 0) begin
      errors++;
      $display("no illegal opcode was executed");
    end

    $display("checks %0d, errors %0d, fetch faults %0d, store faults %0d, masked %0d, illegal %0d",
             checks, errors, fetch_faults, store_faults, masked_faults, illegal_execs);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
